// File: testbench/miniCoreInput.txt
# Test name, instruction, PC, expected rd (ff = branch, no write), write data, branch flag
# Values follow sequential RV32I execution from zeroed registers
addiPos     06400093 00000100 01 00000064 0
addiNeg     ff900113 00000104 02 fffffff9 0
luiBase     123451b7 00000108 03 12345000 0
addiMax     7ff00213 0000010c 04 000007ff 0
addReg      002082b3 00000110 05 0000005d 0
subReg      40208333 00000114 06 0000006b 0
sltReg      001123b3 00000118 07 00000001 0
sltuReg     00113433 0000011c 08 00000000 0
sllReg      002094b3 00000120 09 c8000000 0
srlReg      00415533 00000124 0a 00000001 0
sraReg      4014d5b3 00000128 0b fc800000 0
xorReg      0041c633 0000012c 0c 123457ff 0
orReg       0030e6b3 00000130 0d 12345064 0
andReg      00417733 00000134 0e 000007f9 0
sltiImm     ffa12793 00000138 0f 00000001 0
sltiuImm    fff0b813 0000013c 10 00000001 0
xoriImm     fff0c893 00000140 11 ffffff9b 0
oriImm      0f01e913 00000144 12 123450f0 0
andiImm     0ff17993 00000148 13 000000f9 0
slliImm     00309a13 0000014c 14 00000320 0
srliImm     01c15a93 00000150 15 0000000f 0
sraiImm     40115b13 00000154 16 fffffffc 0
fwdBase     00500b93 00000158 17 00000005 0
fwdDist1    017b8c33 0000015c 18 0000000a 0
fwdDist2    001b8c93 00000160 19 00000006 0
fwdDist3    002b8d13 00000164 1a 00000007 0
fwdBothSrc  419d0db3 00000168 1b 00000001 0
fwdSelfInc  00ad8d93 0000016c 1b 0000000b 0
fwdPriority 000d8e13 00000170 1c 0000000b 0
x0Write     00500013 00000174 00 00000005 0
fwdX0Read   00000eb3 00000178 1d 00000000 0
fwdX0Dist2  00300f13 0000017c 1e 00000003 0
luiHigh     ffffffb7 00000180 1f fffff000 0
auipcAdd    00010297 00000184 05 00010184 0
jalLink     0080036f 00000188 06 0000018c 0
jalrLink    000083e7 0000018c 07 00000190 0
fwdLink     00038413 00000190 08 00000190 0
beqTaken    00108463 00000194 ff 00000000 1
bneTaken    00209463 00000198 ff 00000000 1
bltTaken    00114463 0000019c ff 00000000 1
bgeNot      00115463 000001a0 ff 00000000 0
bltuNot     00116463 000001a4 ff 00000000 0
bgeuTaken   00117463 000001a8 ff 00000000 1
brSetup     00600493 000001ac 09 00000006 0
fwdBranch   01948463 000001b0 ff 00000000 1
readXor     00060533 000001b4 0a 123457ff 0
readSra     0005e5b3 000001b8 0b fc800000 0

// File: project.f
design/miniCorePkg.sv
design/miniCoreDecode.sv
design/miniCoreExe.sv
design/miniCoreResult.sv
design/miniCoreTop.sv
testbench/miniCore_assertions.sv
testbench/miniCoreTb.sv

// File: Bender.yml
package:
  name: mini_core

sources:
  - files:
      - design/miniCorePkg.sv
      - design/miniCoreDecode.sv
      - design/miniCoreExe.sv
      - design/miniCoreResult.sv
      - design/miniCoreTop.sv
  - target: test
    files:
      - testbench/miniCore_assertions.sv
      - testbench/miniCoreTb.sv

// File: testbench/miniCoreTb.sv
/* Testbench for the mini RV32I core.
   Streams the instructions of the input file, one per cycle with random
   idle gaps, and checks each writeback against the values in the file */
`timescale 1ns/1ns

module miniCoreTb;

  localparam int DataWidth   = 32;
  localparam int ResetCycles = 16;
  localparam int MaxTests    = 64;

  logic                                 Clock;
  logic                                 rstN;
  logic                                 InstrValidQ101H;
  miniCorePkg::tInstr                   InstrQ101H;
  logic [DataWidth-1:0]                 PcQ101H;
  logic                                 WbValidQ104H;
  logic [miniCorePkg::RegAddrWidth-1:0] WbRdQ104H;
  logic [DataWidth-1:0]                 WbDataQ104H;
  logic                                 BranchCondMetQ104H;

  // Test table, one entry per line of the input file
  string       testName [MaxTests];
  logic [31:0] instrTab [MaxTests];
  logic [31:0] pcTab    [MaxTests];
  logic [7:0]  rdTab    [MaxTests];  // ff marks a branch without a register write
  logic [31:0] dataTab  [MaxTests];
  logic        brTab    [MaxTests];
  int          numTests;

  int expIdxQ[$];  // Tests in flight with the oldest first
  int passCount, errorCount, checkedCount;
  int cycleCount, cycleLimit;

  miniCoreTop #(.DataWidth(DataWidth)) miniCoreTop_i (
    .Clock              (Clock),
    .rstN               (rstN),
    .InstrValidQ101H    (InstrValidQ101H),
    .InstrQ101H         (InstrQ101H),
    .PcQ101H            (PcQ101H),
    .WbValidQ104H       (WbValidQ104H),
    .WbRdQ104H          (WbRdQ104H),
    .WbDataQ104H        (WbDataQ104H),
    .BranchCondMetQ104H (BranchCondMetQ104H)
  );

  bind miniCoreTop miniCoreAssertions miniCoreAssertions_i (
    .Clock           (Clock),
    .rstN            (rstN),
    .InstrValidQ101H (InstrValidQ101H),
    .ValidQ102H      (ValidQ102H),
    .ValidQ103H      (ValidQ103H),
    .WbValidQ104H    (WbValidQ104H),
    .RegWrEnQ104H    (RegWrEnQ104H),
    .RegDstQ104H     (RegDstQ104H)
  );

  always #20 Clock = ~Clock; // 40 ns period

  //========================================
  // Stimulus file and drive tasks
  //========================================
  task automatic loadTests();
    int                fd;
    int                n;
    logic [8*128-1:0]  line;
    logic [8*24-1:0]   nameVec;
    logic [31:0]       instr, pc, data;
    logic [7:0]        rd;
    logic              br;
    numTests = 0;
    fd = $fopen("testbench/miniCoreInput.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test input file, no tests run");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        if ($fgets(line, fd) != 0) begin
          n = $sscanf(line, "%s %h %h %h %h %h", nameVec, instr, pc, rd, data, br);
          if (n == 6 && numTests < MaxTests) begin // Comments and blanks fail the scan
            testName[numTests] = $sformatf("%0s", nameVec);
            instrTab[numTests] = instr;
            pcTab[numTests]    = pc;
            rdTab[numTests]    = rd;
            dataTab[numTests]  = data;
            brTab[numTests]    = br;
            numTests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic applyTest(input int idx);
    @(posedge Clock);
    #2;
    InstrValidQ101H = 1'b1;
    InstrQ101H      = instrTab[idx];
    PcQ101H         = pcTab[idx];
    expIdxQ.push_back(idx);
  endtask

  task automatic idleCycle();
    @(posedge Clock);
    #2;
    InstrValidQ101H = 1'b0; // Old word stays on the bus and must be ignored
  endtask

  //========================================
  // Writeback and idle checks
  //========================================
  always @(negedge Clock) begin : checkOutputs
    int   idx;
    logic ok;
    logic expWrEn;
    logic wrEn;
    wrEn = miniCoreTop_i.RegWrEnQ104H;
    if (rstN && WbValidQ104H) begin
      assert (expIdxQ.size() != 0) else begin
        errorCount++;
        $display("Writeback seen with no instruction outstanding at cycle %0d", cycleCount);
      end
      if (expIdxQ.size() != 0) begin
        idx     = expIdxQ.pop_front();
        expWrEn = (rdTab[idx] != 8'hff) && (rdTab[idx] != 8'h00);
        if (rdTab[idx] == 8'hff) begin
          ok = (BranchCondMetQ104H === brTab[idx]) && (wrEn === 1'b0);
        end else begin
          ok = (WbRdQ104H === rdTab[idx][4:0]) && (WbDataQ104H === dataTab[idx]) &&
               (wrEn === expWrEn) && (BranchCondMetQ104H === brTab[idx]);
        end
        assert (ok) begin
          passCount++;
          $display("PASS    %s", testName[idx]);
        end else begin
          errorCount++;
          $write("[ERROR] %s expected rd=%h data=%h wr=%b br=%b", testName[idx],
                 rdTab[idx], dataTab[idx], expWrEn, brTab[idx]);
          $display(", actual rd=%h data=%h wr=%b br=%b",
                   WbRdQ104H, WbDataQ104H, wrEn, BranchCondMetQ104H);
        end
        checkedCount++;
      end
    end else if (cycleCount > 0) begin
      // Nothing may look active in reset or a bubble
      assert (!WbValidQ104H && !BranchCondMetQ104H && !wrEn) else begin
        errorCount++;
        $display("Outputs active during reset or an idle cycle at cycle %0d", cycleCount);
      end
    end
  end

  always @(posedge Clock) begin : watchdog
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, only %0d of %0d tests completed",
               cycleCount, checkedCount, numTests);
      $display("Regression failed");
      $finish;
    end
  end

  //========================================
  // Main sequence
  //========================================
  initial begin
    int gap;
    int seedDummy;
    int assertFails;
    Clock           = 1'b0;
    rstN            = 1'b0;
    InstrValidQ101H = 1'b0;
    InstrQ101H      = '0;
    PcQ101H         = '0;
    passCount       = 0;
    errorCount      = 0;
    checkedCount    = 0;
    cycleCount      = 0;
    cycleLimit      = ResetCycles + 64;
    seedDummy       = $urandom(32'h6b1f);
    loadTests();
    cycleLimit = ResetCycles + 3 * numTests + 64; // Each test at most 1 cycle plus 2 idle

    repeat (ResetCycles) @(posedge Clock);
    #2;
    rstN = 1'b1;

    for (int i = 0; i < numTests; i++) begin
      // Forwarding tests need their exact distance so no gap goes before them
      if (i > 0 && testName[i].substr(0, 2) != "fwd") begin
        gap = $urandom % 3;
        repeat (gap) idleCycle();
      end
      applyTest(i);
    end
    idleCycle();

    wait (checkedCount == numTests);
    repeat (4) @(posedge Clock); // Drain to catch stray writebacks
    assertFails = miniCoreTop_i.miniCoreAssertions_i.failCount;
    $display("Tests %0d, passed %0d, errors %0d, assertion failures %0d",
             numTests, passCount, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0 && numTests > 0 && passCount == numTests) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: testbench/miniCore_assertions.sv
/* Concurrent checks on the mini core pipeline.
   Bound to miniCoreTop from the testbench */
`timescale 1ns/1ns

module miniCoreAssertions (
  input logic                                 Clock,
  input logic                                 rstN,
  input logic                                 InstrValidQ101H,
  input logic                                 ValidQ102H,
  input logic                                 ValidQ103H,
  input logic                                 WbValidQ104H,
  input logic                                 RegWrEnQ104H,
  input logic [miniCorePkg::RegAddrWidth-1:0] RegDstQ104H
);

  int failCount = 0; // Failed assertions so far

  // Every accepted instruction completes three edges later
  latencyCheck: assert property (@(posedge Clock) disable iff (!rstN)
    WbValidQ104H == $past(InstrValidQ101H, 3))
    else begin
      $error("Writeback valid does not follow the instruction strobe by 3 cycles");
      failCount++;
    end

  // x0 is never a write target
  noWriteX0: assert property (@(posedge Clock) disable iff (!rstN)
    RegWrEnQ104H |-> (RegDstQ104H != '0))
    else begin
      $error("Register write enabled with destination x0");
      failCount++;
    end

  resetClears: assert property (@(posedge Clock)
    !rstN |=> !(ValidQ102H || ValidQ103H || WbValidQ104H || RegWrEnQ104H))
    else begin
      $error("Pipeline valid or write enable still set after reset");
      failCount++;
    end

endmodule

// File: design/miniCoreTop.sv
/* Top level of the mini RV32I core.
   Chains decode, execute and result; one instruction per cycle in,
   its writeback three cycles later */
`timescale 1ns/1ns

module miniCoreTop #(
  parameter int DataWidth = 32
) (
  input  logic                                 Clock,
  input  logic                                 rstN,
  input  logic                                 InstrValidQ101H,
  input  miniCorePkg::tInstr                   InstrQ101H,
  input  logic [DataWidth-1:0]                 PcQ101H,
  output logic                                 WbValidQ104H,
  output logic [miniCorePkg::RegAddrWidth-1:0] WbRdQ104H,
  output logic [DataWidth-1:0]                 WbDataQ104H,
  output logic                                 BranchCondMetQ104H
);

  // Decode to execute
  logic                                 ValidQ102H, RegWrEnQ102H;
  logic [miniCorePkg::RegAddrWidth-1:0] RegSrc1Q102H, RegSrc2Q102H, RegDstQ102H;
  miniCorePkg::tAluOp                   AluOpQ102H;
  miniCorePkg::tBranchOp                BranchOpQ102H;
  logic                                 SelAluPcQ102H, SelAluImmQ102H, LuiQ102H, LinkQ102H;
  logic [DataWidth-1:0]                 PreRegRdData1Q102H, PreRegRdData2Q102H;
  logic [DataWidth-1:0]                 PcQ102H, ImmediateQ102H;
  // Execute to result
  logic                                 ValidQ103H, RegWrEnQ103H, LinkQ103H, BranchCondMetQ103H;
  logic [miniCorePkg::RegAddrWidth-1:0] RegDstQ103H;
  logic [DataWidth-1:0]                 AluOutQ103H, PcPlus4Q103H;
  // Writeback, back to decode and execute
  logic                                 RegWrEnQ104H;
  logic [miniCorePkg::RegAddrWidth-1:0] RegDstQ104H;
  logic [DataWidth-1:0]                 RegWrDataQ104H;

  assign WbRdQ104H   = RegDstQ104H;
  assign WbDataQ104H = RegWrDataQ104H;

  miniCoreDecode #(.DataWidth(DataWidth)) miniCoreDecode_i (.*);
  miniCoreExe    #(.DataWidth(DataWidth)) miniCoreExe_i    (.*);
  miniCoreResult #(.DataWidth(DataWidth)) miniCoreResult_i (.*);

endmodule

// File: design/miniCoreResult.sv
/* Q103H result stage of the mini core.
   Picks the writeback value and registers the Q104H write port,
   which feeds the register file, forwarding and the core outputs */
`timescale 1ns/1ns

module miniCoreResult #(
  parameter int DataWidth = 32
) (
  input  logic                                 Clock,
  input  logic                                 rstN,
  input  logic                                 ValidQ103H,
  input  logic [miniCorePkg::RegAddrWidth-1:0] RegDstQ103H,
  input  logic                                 RegWrEnQ103H,
  input  logic                                 LinkQ103H,
  input  logic [DataWidth-1:0]                 AluOutQ103H,
  input  logic [DataWidth-1:0]                 PcPlus4Q103H,
  input  logic                                 BranchCondMetQ103H,
  output logic                                 RegWrEnQ104H,  // Real writes only
  output logic [miniCorePkg::RegAddrWidth-1:0] RegDstQ104H,
  output logic [DataWidth-1:0]                 RegWrDataQ104H,
  output logic                                 WbValidQ104H,  // Every finished instruction
  output logic                                 BranchCondMetQ104H
);

  logic [DataWidth-1:0] RegWrDataQ103H;

  assign RegWrDataQ103H = LinkQ103H ? PcPlus4Q103H : AluOutQ103H; // JAL, JALR

  //========================================
  // Q103H to Q104H
  //========================================
  always_ff @(posedge Clock) begin : ctrlQ104H
    if (!rstN) begin
      WbValidQ104H       <= 1'b0;
      RegWrEnQ104H       <= 1'b0;
      BranchCondMetQ104H <= 1'b0;
    end else begin
      WbValidQ104H       <= ValidQ103H;
      RegWrEnQ104H       <= ValidQ103H && RegWrEnQ103H;
      BranchCondMetQ104H <= BranchCondMetQ103H;
    end
  end

  always_ff @(posedge Clock) begin : dataQ104H
    RegDstQ104H    <= RegDstQ103H;
    RegWrDataQ104H <= RegWrDataQ103H;
  end

endmodule

// File: design/miniCoreExe.sv
/* Q102H execute stage of the mini core.
   Forwards Q103H and Q104H results, runs the ALU and the branch compare,
   and registers the outcome into Q103H */
`timescale 1ns/1ns

module miniCoreExe #(
  parameter int DataWidth = 32
) (
  input  logic                                 Clock,
  input  logic                                 rstN,
  // Q102H from decode
  input  logic                                 ValidQ102H,
  input  logic [miniCorePkg::RegAddrWidth-1:0] RegSrc1Q102H,
  input  logic [miniCorePkg::RegAddrWidth-1:0] RegSrc2Q102H,
  input  logic [miniCorePkg::RegAddrWidth-1:0] RegDstQ102H,
  input  logic                                 RegWrEnQ102H,
  input  miniCorePkg::tAluOp                   AluOpQ102H,
  input  miniCorePkg::tBranchOp                BranchOpQ102H,
  input  logic                                 SelAluPcQ102H,
  input  logic                                 SelAluImmQ102H,
  input  logic                                 LuiQ102H,
  input  logic                                 LinkQ102H,
  input  logic [DataWidth-1:0]                 PreRegRdData1Q102H,
  input  logic [DataWidth-1:0]                 PreRegRdData2Q102H,
  input  logic [DataWidth-1:0]                 PcQ102H,
  input  logic [DataWidth-1:0]                 ImmediateQ102H,
  // Q104H writeback for forwarding
  input  logic [miniCorePkg::RegAddrWidth-1:0] RegDstQ104H,
  input  logic                                 RegWrEnQ104H,
  input  logic [DataWidth-1:0]                 RegWrDataQ104H,
  // Q103H out
  output logic                                 ValidQ103H,
  output logic [miniCorePkg::RegAddrWidth-1:0] RegDstQ103H,
  output logic                                 RegWrEnQ103H,
  output logic                                 LinkQ103H,
  output logic [DataWidth-1:0]                 AluOutQ103H,
  output logic [DataWidth-1:0]                 PcPlus4Q103H,
  output logic                                 BranchCondMetQ103H
);

  logic                 Hazard3Src1Q102H, Hazard4Src1Q102H;
  logic                 Hazard3Src2Q102H, Hazard4Src2Q102H;
  logic [DataWidth-1:0] FwdDataQ103H;  // What Q103H will write
  logic [DataWidth-1:0] RegRdData1Q102H, RegRdData2Q102H;
  logic [DataWidth-1:0] AluIn1Q102H, AluIn2Q102H, AluOutQ102H;
  logic [4:0]           ShamtQ102H;
  logic                 BranchCondMetQ102H;

  //========================================
  // Hazards and forwarding
  //========================================
  assign Hazard3Src1Q102H = RegWrEnQ103H && (RegDstQ103H == RegSrc1Q102H) && (RegSrc1Q102H != '0);
  assign Hazard4Src1Q102H = RegWrEnQ104H && (RegDstQ104H == RegSrc1Q102H) && (RegSrc1Q102H != '0);
  assign Hazard3Src2Q102H = RegWrEnQ103H && (RegDstQ103H == RegSrc2Q102H) && (RegSrc2Q102H != '0);
  assign Hazard4Src2Q102H = RegWrEnQ104H && (RegDstQ104H == RegSrc2Q102H) && (RegSrc2Q102H != '0);

  // Jumps write the link value, not the target
  assign FwdDataQ103H = LinkQ103H ? PcPlus4Q103H : AluOutQ103H;

  assign RegRdData1Q102H = Hazard3Src1Q102H ? FwdDataQ103H   :  // Newest first
                           Hazard4Src1Q102H ? RegWrDataQ104H :
                                              PreRegRdData1Q102H;
  assign RegRdData2Q102H = Hazard3Src2Q102H ? FwdDataQ103H   :
                           Hazard4Src2Q102H ? RegWrDataQ104H :
                                              PreRegRdData2Q102H;

  assign AluIn1Q102H = SelAluPcQ102H  ? PcQ102H        : RegRdData1Q102H; // AUIPC, JAL
  assign AluIn2Q102H = SelAluImmQ102H ? ImmediateQ102H : RegRdData2Q102H;
  assign ShamtQ102H  = AluIn2Q102H[4:0];

  //========================================
  // ALU
  //========================================
  always_comb begin : alu
    case (AluOpQ102H)
      miniCorePkg::SUB:  AluOutQ102H = AluIn1Q102H - AluIn2Q102H;
      miniCorePkg::SLT:  AluOutQ102H = DataWidth'($signed(AluIn1Q102H) < $signed(AluIn2Q102H));
      miniCorePkg::SLTU: AluOutQ102H = DataWidth'(AluIn1Q102H < AluIn2Q102H);
      miniCorePkg::SLL:  AluOutQ102H = AluIn1Q102H << ShamtQ102H;
      miniCorePkg::SRL:  AluOutQ102H = AluIn1Q102H >> ShamtQ102H;
      miniCorePkg::SRA:  AluOutQ102H = $signed(AluIn1Q102H) >>> ShamtQ102H;
      miniCorePkg::XOR:  AluOutQ102H = AluIn1Q102H ^ AluIn2Q102H;
      miniCorePkg::OR:   AluOutQ102H = AluIn1Q102H | AluIn2Q102H;
      miniCorePkg::AND:  AluOutQ102H = AluIn1Q102H & AluIn2Q102H;
      default:           AluOutQ102H = AluIn1Q102H + AluIn2Q102H; // ADD, targets
    endcase
    if (LuiQ102H) begin
      AluOutQ102H = AluIn2Q102H; // Upper immediate as is
    end
  end

  // Compare on forwarded registers, never on the ALU inputs
  always_comb begin : branchCompare
    case (BranchOpQ102H)
      miniCorePkg::BEQ:  BranchCondMetQ102H = (RegRdData1Q102H == RegRdData2Q102H);
      miniCorePkg::BNE:  BranchCondMetQ102H = (RegRdData1Q102H != RegRdData2Q102H);
      miniCorePkg::BLT:  BranchCondMetQ102H = $signed(RegRdData1Q102H) < $signed(RegRdData2Q102H);
      miniCorePkg::BGE:  BranchCondMetQ102H = $signed(RegRdData1Q102H) >= $signed(RegRdData2Q102H);
      miniCorePkg::BLTU: BranchCondMetQ102H = (RegRdData1Q102H < RegRdData2Q102H);
      miniCorePkg::BGEU: BranchCondMetQ102H = (RegRdData1Q102H >= RegRdData2Q102H);
      default:           BranchCondMetQ102H = 1'b0; // NOBR
    endcase
  end

  // Q102H to Q103H
  always_ff @(posedge Clock) begin : ctrlQ103H
    if (!rstN) begin
      ValidQ103H         <= 1'b0;
      RegWrEnQ103H       <= 1'b0;
      LinkQ103H          <= 1'b0;
      BranchCondMetQ103H <= 1'b0;
    end else begin
      ValidQ103H         <= ValidQ102H;
      RegWrEnQ103H       <= RegWrEnQ102H;
      LinkQ103H          <= LinkQ102H;
      BranchCondMetQ103H <= ValidQ102H && BranchCondMetQ102H;
    end
  end

  always_ff @(posedge Clock) begin : dataQ103H
    RegDstQ103H  <= RegDstQ102H;
    AluOutQ103H  <= AluOutQ102H;
    PcPlus4Q103H <= PcQ102H + DataWidth'(4); // Link value
  end

endmodule

// File: design/miniCoreDecode.sv
/* Q101H decode stage of the mini core.
   Splits the instruction into controls and an immediate, reads the register
   file with Q104H write-through, and registers everything into Q102H */
`timescale 1ns/1ns

module miniCoreDecode #(
  parameter int DataWidth = 32
) (
  input  logic                                 Clock,
  input  logic                                 rstN,
  // Instruction stream
  input  logic                                 InstrValidQ101H,
  input  miniCorePkg::tInstr                   InstrQ101H,
  input  logic [DataWidth-1:0]                 PcQ101H,
  // Register file write port from Q104H
  input  logic                                 RegWrEnQ104H,
  input  logic [miniCorePkg::RegAddrWidth-1:0] RegDstQ104H,
  input  logic [DataWidth-1:0]                 RegWrDataQ104H,
  // Q102H controls
  output logic                                 ValidQ102H,
  output logic [miniCorePkg::RegAddrWidth-1:0] RegSrc1Q102H,
  output logic [miniCorePkg::RegAddrWidth-1:0] RegSrc2Q102H,
  output logic [miniCorePkg::RegAddrWidth-1:0] RegDstQ102H,
  output logic                                 RegWrEnQ102H,
  output miniCorePkg::tAluOp                   AluOpQ102H,
  output miniCorePkg::tBranchOp                BranchOpQ102H,
  output logic                                 SelAluPcQ102H,
  output logic                                 SelAluImmQ102H,
  output logic                                 LuiQ102H,
  output logic                                 LinkQ102H,
  // Q102H data
  output logic [DataWidth-1:0]                 PreRegRdData1Q102H,
  output logic [DataWidth-1:0]                 PreRegRdData2Q102H,
  output logic [DataWidth-1:0]                 PcQ102H,
  output logic [DataWidth-1:0]                 ImmediateQ102H
);

  localparam int NumRegs = 2**miniCorePkg::RegAddrWidth;

  logic [DataWidth-1:0] RegFile [1:NumRegs-1]; // x0 not stored
  logic [miniCorePkg::RegAddrWidth-1:0] RegSrc1Q101H, RegSrc2Q101H, RegDstQ101H;
  logic [DataWidth-1:0] PreRegRdData1Q101H, PreRegRdData2Q101H;
  logic [31:0]          ImmIQ101H, ImmBQ101H, ImmUQ101H, ImmJQ101H;
  logic [31:0]          Imm32Q101H;
  logic                 SubQ101H;
  logic                 WritesRdQ101H;
  logic                 SelAluPcQ101H, SelAluImmQ101H, LuiQ101H, LinkQ101H;
  miniCorePkg::tAluOp    FunctAluOpQ101H, AluOpQ101H;
  miniCorePkg::tBranchOp BranchOpQ101H;

  assign RegSrc1Q101H = InstrQ101H.rType.rs1;
  assign RegSrc2Q101H = InstrQ101H.rType.rs2;
  assign RegDstQ101H  = InstrQ101H.rType.rd;

  //========================================
  // Immediates per format
  //========================================
  assign ImmIQ101H = {{20{InstrQ101H.rType.funct7[6]}}, InstrQ101H.rType.funct7,
                      InstrQ101H.rType.rs2};
  assign ImmBQ101H = {{20{InstrQ101H.rType.funct7[6]}}, InstrQ101H.rType.rd[0],
                      InstrQ101H.rType.funct7[5:0], InstrQ101H.rType.rd[4:1], 1'b0};
  assign ImmUQ101H = {InstrQ101H.uType.immUpper, 12'b0};
  assign ImmJQ101H = {{12{InstrQ101H.uType.immUpper[19]}}, InstrQ101H.uType.immUpper[7:0],
                      InstrQ101H.uType.immUpper[8], InstrQ101H.uType.immUpper[18:9], 1'b0};

  // funct7 bit 5 means SUB only on R-type, ADDI has imm bits there
  assign SubQ101H = (InstrQ101H.rType.opcode == miniCorePkg::OPREG) &&
                    InstrQ101H.rType.funct7[5];

  always_comb begin : functDecode
    case (InstrQ101H.rType.funct3)
      3'b000:  FunctAluOpQ101H = SubQ101H ? miniCorePkg::SUB : miniCorePkg::ADD;
      3'b001:  FunctAluOpQ101H = miniCorePkg::SLL;
      3'b010:  FunctAluOpQ101H = miniCorePkg::SLT;
      3'b011:  FunctAluOpQ101H = miniCorePkg::SLTU;
      3'b100:  FunctAluOpQ101H = miniCorePkg::XOR;
      3'b101:  FunctAluOpQ101H = InstrQ101H.rType.funct7[5] ? miniCorePkg::SRA :
                                                              miniCorePkg::SRL;
      3'b110:  FunctAluOpQ101H = miniCorePkg::OR;
      default: FunctAluOpQ101H = miniCorePkg::AND;
    endcase
  end

  always_comb begin : ctrlDecode
    AluOpQ101H     = miniCorePkg::ADD;  // Target adds for jumps and branches
    BranchOpQ101H  = miniCorePkg::NOBR;
    SelAluPcQ101H  = 1'b0;
    SelAluImmQ101H = 1'b1;
    LuiQ101H       = 1'b0;
    LinkQ101H      = 1'b0;
    WritesRdQ101H  = 1'b1;
    Imm32Q101H     = ImmIQ101H;
    case (InstrQ101H.rType.opcode)
      miniCorePkg::OPREG: begin
        AluOpQ101H     = FunctAluOpQ101H;
        SelAluImmQ101H = 1'b0;
      end
      miniCorePkg::OPIMM:  AluOpQ101H = FunctAluOpQ101H;
      miniCorePkg::LUI: begin
        LuiQ101H   = 1'b1;      // ALU passes the immediate
        Imm32Q101H = ImmUQ101H;
      end
      miniCorePkg::AUIPC: begin
        SelAluPcQ101H = 1'b1;   // PC + upper immediate
        Imm32Q101H    = ImmUQ101H;
      end
      miniCorePkg::JAL: begin
        SelAluPcQ101H = 1'b1;
        LinkQ101H     = 1'b1;
        Imm32Q101H    = ImmJQ101H;
      end
      miniCorePkg::JALR:   LinkQ101H = 1'b1; // rs1 + imm
      miniCorePkg::BRANCH: begin
        BranchOpQ101H = miniCorePkg::tBranchOp'(InstrQ101H.rType.funct3);
        if (InstrQ101H.rType.funct3[2:1] == 2'b01) begin
          BranchOpQ101H = miniCorePkg::NOBR; // Reserved funct3
        end
        SelAluPcQ101H = 1'b1;
        WritesRdQ101H = 1'b0;
        Imm32Q101H    = ImmBQ101H;
      end
      default:             WritesRdQ101H = 1'b0; // Unsupported, flows as a bubble
    endcase
  end

  //========================================
  // Register file, write at end of Q104H
  //========================================
  always_ff @(posedge Clock) begin : regFileWrite
    if (!rstN) begin
      for (int i = 1; i < NumRegs; i++) begin
        RegFile[i] <= '0;
      end
    end else if (RegWrEnQ104H && (RegDstQ104H != '0)) begin
      RegFile[RegDstQ104H] <= RegWrDataQ104H;
    end
  end

  // x0 first, then the write landing this cycle
  assign PreRegRdData1Q101H = (RegSrc1Q101H == '0)                            ? '0 :
                              (RegWrEnQ104H && (RegDstQ104H == RegSrc1Q101H)) ? RegWrDataQ104H :
                                                                    RegFile[RegSrc1Q101H];
  assign PreRegRdData2Q101H = (RegSrc2Q101H == '0)                            ? '0 :
                              (RegWrEnQ104H && (RegDstQ104H == RegSrc2Q101H)) ? RegWrDataQ104H :
                                                                    RegFile[RegSrc2Q101H];

  // Q101H to Q102H, controls gated by the strobe
  always_ff @(posedge Clock) begin : ctrlQ102H
    if (!rstN) begin
      ValidQ102H     <= 1'b0;
      RegWrEnQ102H   <= 1'b0;
      BranchOpQ102H  <= miniCorePkg::NOBR;
      LinkQ102H      <= 1'b0;
    end else begin
      ValidQ102H     <= InstrValidQ101H;
      RegWrEnQ102H   <= InstrValidQ101H && WritesRdQ101H && (RegDstQ101H != '0);
      BranchOpQ102H  <= InstrValidQ101H ? BranchOpQ101H : miniCorePkg::NOBR;
      LinkQ102H      <= InstrValidQ101H && LinkQ101H;
    end
  end

  always_ff @(posedge Clock) begin : dataQ102H
    RegSrc1Q102H       <= RegSrc1Q101H;
    RegSrc2Q102H       <= RegSrc2Q101H;
    RegDstQ102H        <= RegDstQ101H;
    AluOpQ102H         <= AluOpQ101H;
    SelAluPcQ102H      <= InstrValidQ101H && SelAluPcQ101H;
    SelAluImmQ102H     <= InstrValidQ101H && SelAluImmQ101H;
    LuiQ102H           <= InstrValidQ101H && LuiQ101H;
    PreRegRdData1Q102H <= PreRegRdData1Q101H;
    PreRegRdData2Q102H <= PreRegRdData2Q101H;
    PcQ102H            <= PcQ101H;
    ImmediateQ102H     <= DataWidth'($signed(Imm32Q101H)); // Sign extend to width
  end

endmodule

// File: design/miniCorePkg.sv
/* Shared encodings for the mini RV32I core.
   Opcodes, ALU and branch operations and the instruction word layouts.
   Refer to members by scoped name, e.g. miniCorePkg::ADD */

package miniCorePkg;

  // Data path width is a module parameter, DataWidth, 32 by default
  localparam int RegAddrWidth = 5; // x0..x31

  //========================================
  // Major opcodes
  //========================================
  typedef enum logic [6:0] {
    OPREG  = 7'b0110011,  // R-type arithmetic
    OPIMM  = 7'b0010011,  // I-type arithmetic
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011
  } tOpcode;

  typedef enum logic [3:0] {
    ADD, SUB, SLT, SLTU,  // Adder group
    SLL, SRL, SRA,        // Shifter
    XOR, OR, AND          // Bitwise
  } tAluOp;

  // Values follow funct3 of the branch encoding
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    NOBR = 3'b010,  // Not a branch, flag stays 0
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } tBranchOp;

  //========================================
  // Instruction word, two views
  //========================================
  typedef struct packed {
    logic [6:0] funct7;   // Also imm[11:5] for I and B
    logic [4:0] rs2;      // Also imm[4:0] for I
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;       // Also B imm bits
    tOpcode     opcode;
  } tRType;

  typedef struct packed {
    logic [19:0] immUpper; // U immediate or scrambled J immediate
    logic [4:0]  rd;
    tOpcode      opcode;
  } tUType;

  typedef union packed {
    tRType rType;
    tUType uType;
  } tInstr;

endpackage
